// File: sim.f
+incdir+rtl
+incdir+sim
rtl/md_op_pkg.sv
rtl/md_data_pkg.sv
rtl/md_mult_mac.sv
rtl/md_div_serial.sv
rtl/md_sequencer.sv
rtl/md_unit.sv
sim/tb_md_unit.sv

// File: Bender.yml
package:
  name: md_unit

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/md_op_pkg.sv
      - rtl/md_data_pkg.sv
      - rtl/md_mult_mac.sv
      - rtl/md_div_serial.sv
      - rtl/md_sequencer.sv
      - rtl/md_unit.sv
  - target: simulation
    include_dirs:
      - rtl
      - sim
    files:
      - sim/tb_md_unit.sv

// File: sim/tb_md_checks.svh
// Reference model and directed tests for the multiply/divide testbench.
// Included inside tb_md_unit, where the drive and check helpers live.

`ifndef TB_MD_CHECKS_SVH
`define TB_MD_CHECKS_SVH

function automatic md_req_t make_req(input logic [2:0] f3, input logic [`MD_XLEN-1:0] a,
                                     input logic [`MD_XLEN-1:0] b);
  md_req_t req;
  req.funct = f3;
  req.op_a  = a;
  req.op_b  = b;
  return req;
endfunction

// RV32M result worked out with 64-bit arithmetic
function automatic logic [`MD_XLEN-1:0] ref_result(input md_req_t req);
  longint          sa;
  longint          sb;
  longint unsigned ua;
  longint unsigned ub;
  logic [63:0]     wide;
  sa = longint'($signed(req.op_a));
  sb = longint'($signed(req.op_b));
  ua = {32'b0, req.op_a};
  ub = {32'b0, req.op_b};
  if (!req.funct.mul.is_div) begin
    case (req.funct.mul.kind)
      MD_MULH:   wide = sa * sb;
      MD_MULHSU: wide = sa * longint'(ub);
      default:   wide = ua * ub;
    endcase
    return (req.funct.mul.kind == MD_MUL) ? wide[31:0] : wide[63:32];
  end
  // Zero divisor gives all ones, or the dividend for a remainder
  if (req.op_b == '0) begin
    return req.funct.div.rem ? req.op_a : '1;
  end
  if (req.funct.div.uns) begin
    wide = req.funct.div.rem ? (ua % ub) : (ua / ub);
  end else begin
    // Wide operands keep the most negative value over -1 exact
    wide = req.funct.div.rem ? (sa % sb) : (sa / sb);
  end
  return wide[31:0];
endfunction

task automatic test_reset_state();
  @(negedge clk_i);
  check_flag("test_reset_state valid_o", 1'b0, valid_o);
  check_flag("test_reset_state busy_o", 1'b0, busy_o);
endtask

task automatic test_mul_kinds();
  logic [`MD_XLEN-1:0] corners [5];
  md_req_t             req;
  int                  lat;
  corners = '{32'h0, 32'h1, 32'hFFFF_FFFF, 32'h8000_0000, 32'h7FFF_FFFF};
  for (int k = 0; k < 4; k++) begin
    for (int n = 0; n < 45; n++) begin
      // Every corner pair first, then random pairs
      if (n < 25) begin
        req = make_req(3'(k), corners[n / 5], corners[n % 5]);
      end else begin
        req = make_req(3'(k), $urandom, $urandom);
      end
      run_op($sformatf("test_mul_kinds f3=%0d", k), req, lat);
      check_value($sformatf("test_mul_kinds latency f3=%0d", k), (k == 0) ? 4 : 5, lat);
    end
  end
endtask

task automatic test_div_rem();
  logic [`MD_XLEN-1:0] a;
  logic [`MD_XLEN-1:0] b;
  int                  lat;
  for (int n = 0; n < 20; n++) begin
    a = $urandom >> 1;
    // Divisor sizes spread from tiny to nearly full width
    b = ($urandom >> ($urandom % 31)) | 32'h1;
    if (n[0]) begin
      a = -a;
    end
    if (n[1]) begin
      b = -b;
    end
    for (int k = 4; k < 8; k++) begin
      run_op($sformatf("test_div_rem f3=%0d", k), make_req(3'(k), a, b), lat);
    end
  end
  for (int k = 4; k < 8; k++) begin
    run_op($sformatf("test_div_rem overflow f3=%0d", k),
           make_req(3'(k), 32'h8000_0000, 32'hFFFF_FFFF), lat);
  end
endtask

task automatic test_div_zero();
  int lat;
  for (int k = 4; k < 8; k++) begin
    run_op($sformatf("test_div_zero f3=%0d", k), make_req(3'(k), $urandom, '0), lat);
    check_value($sformatf("test_div_zero latency f3=%0d", k), 2, lat);
  end
endtask

task automatic test_backpressure();
  logic [2:0]          kinds [4];
  md_req_t             req;
  logic [`MD_XLEN-1:0] held;
  int                  lat;
  int                  hold;
  kinds = '{3'd0, 3'd3, 3'd4, 3'd7};
  foreach (kinds[i]) begin
    req  = make_req(kinds[i], $urandom, $urandom | 32'h1);
    hold = 1 + ($urandom % 10);
    @(posedge clk_i);
    ready_i <= 1'b0;
    start_request(req);
    wait_result("test_backpressure", held, lat);
    check_value("test_backpressure result", ref_result(req), held);
    repeat (hold) begin
      @(negedge clk_i);
      check_flag("test_backpressure valid_o", 1'b1, valid_o);
      check_flag("test_backpressure busy_o", 1'b1, busy_o);
      check_value("test_backpressure result_o", held, result_o);
    end
    @(posedge clk_i);
    ready_i <= 1'b1;
    // Ready takes effect on the following edge
    @(negedge clk_i);
    check_flag("test_backpressure valid_o with ready", 1'b1, valid_o);
    check_flag("test_backpressure busy_o with ready", 1'b1, busy_o);
    check_value("test_backpressure result_o with ready", held, result_o);
    @(negedge clk_i);
    check_flag("test_backpressure valid_o after ready", 1'b0, valid_o);
    check_flag("test_backpressure busy_o after ready", 1'b0, busy_o);
  end
endtask

task automatic test_busy_ignore();
  md_req_t             first;
  md_req_t             second;
  logic [`MD_XLEN-1:0] res;
  int                  lat;
  int                  extra;
  first  = make_req(3'd4, $urandom, ($urandom >> 8) | 32'h1);
  second = make_req(3'd0, $urandom, $urandom);
  start_request(first);
  repeat (3) @(negedge clk_i);
  check_flag("test_busy_ignore busy_o", 1'b1, busy_o);
  @(posedge clk_i);
  start_i <= 1'b1;
  req_i   <= second;
  @(posedge clk_i);
  start_i <= 1'b0;
  wait_result("test_busy_ignore", res, lat);
  check_value("test_busy_ignore result", ref_result(first), res);
  // The ignored request must never produce a result of its own
  extra = 0;
  @(posedge clk_i);
  repeat (MaxLatency) begin
    @(negedge clk_i);
    if (valid_o) begin
      extra++;
    end
  end
  check_value("test_busy_ignore extra results", 0, extra);
endtask

`endif

// File: sim/tb_md_unit.sv
// Directed testbench for the RV32M multiply/divide unit.
// Drives md_unit through the tests in tb_md_checks.svh and checks every result.

`include "md_settings.svh"

module tb_md_unit
  import md_op_pkg::*;
  import md_data_pkg::*;
();

  localparam int ClkPeriod  = 20;
  localparam int MaxLatency = 60;
  // Operations issued over all tests
  localparam int NumOps         = 273;
  localparam int WatchdogCycles = 40 * NumOps + 200;

  logic                clk_i;
  logic                rst_ni;
  logic                start_i;
  md_req_t             req_i;
  logic                ready_i;
  logic                busy_o;
  logic                valid_o;
  logic [`MD_XLEN-1:0] result_o;

  md_unit i_md_unit (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .start_i  (start_i),
    .req_i    (req_i),
    .ready_i  (ready_i),
    .busy_o   (busy_o),
    .valid_o  (valid_o),
    .result_o (result_o)
  );

  always #(ClkPeriod / 2) clk_i = ~clk_i;

  task automatic check_value(input string name, input logic [`MD_XLEN-1:0] exp_val,
                             input logic [`MD_XLEN-1:0] act_val);
    assert (act_val === exp_val) else begin
      $display("FAILED %s: expected %h, actual %h", name, exp_val, act_val);
      $display("TESTS FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic check_flag(input string name, input logic exp_val, input logic act_val);
    assert (act_val === exp_val) else begin
      $display("FAILED %s: expected %b, actual %b", name, exp_val, act_val);
      $display("TESTS FAILED");
      $fatal(1, "flag mismatch");
    end
  endtask

  // Waits until the unit is free, then holds start_i high over one edge
  task automatic start_request(input md_req_t req);
    @(negedge clk_i);
    while (busy_o) begin
      @(negedge clk_i);
    end
    @(posedge clk_i);
    start_i <= 1'b1;
    req_i   <= req;
    @(posedge clk_i);
    start_i <= 1'b0;
  endtask

  // Counts edges after the accepting edge until valid_o shows up
  task automatic wait_result(input string name, output logic [`MD_XLEN-1:0] res,
                             output int lat);
    lat = 0;
    do begin
      @(posedge clk_i);
      lat++;
      @(negedge clk_i);
    end while (!valid_o && lat < MaxLatency);
    assert (valid_o) else begin
      $display("%s: valid_o did not rise within %0d cycles of the start", name, MaxLatency);
      $display("TESTS FAILED");
      $fatal(1, "missing result");
    end
    res = result_o;
  endtask

  task automatic run_op(input string name, input md_req_t req, output int lat);
    logic [`MD_XLEN-1:0] res;
    start_request(req);
    wait_result(name, res, lat);
    check_value(name, ref_result(req), res);
  endtask

  `include "tb_md_checks.svh"

  initial begin
    void'($urandom(84));
    clk_i    = 1'b0;
    rst_ni   = 1'b0;
    start_i  = 1'b0;
    req_i    = '0;
    ready_i  = 1'b1;
    repeat (16) @(posedge clk_i);
    rst_ni <= 1'b1;
    test_reset_state();
    test_mul_kinds();
    test_div_rem();
    test_div_zero();
    test_backpressure();
    test_busy_ignore();
    $display("TESTS PASSED");
    $finish;
  end

  // Ends a hung run after a limit that scales with the operation count
  initial begin
    #(WatchdogCycles * ClkPeriod);
    $display("Watchdog expired after %0d cycles, the DUT stopped responding", WatchdogCycles);
    $display("TESTS FAILED");
    $fatal(1, "watchdog timeout");
  end

endmodule

// File: rtl/md_unit.sv
// Top of the RV32M multiply/divide unit.
// Pulse start_i with req_i while busy_o is low, then take result_o
// in a cycle where valid_o and ready_i are both high.

`include "md_settings.svh"

module md_unit
  import md_data_pkg::*;
(
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                start_i,
  input  md_req_t             req_i,
  input  logic                ready_i,
  output logic                busy_o,
  output logic                valid_o,
  output logic [`MD_XLEN-1:0] result_o
);

  logic    mul_start;
  logic    div_start;
  md_res_t mul_res;
  md_res_t div_res;

  md_sequencer i_md_sequencer (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .start_i     (start_i),
    .req_i       (req_i),
    .mul_res_i   (mul_res),
    .div_res_i   (div_res),
    .ready_i     (ready_i),
    .mul_start_o (mul_start),
    .div_start_o (div_start),
    .busy_o      (busy_o),
    .valid_o     (valid_o),
    .result_o    (result_o)
  );

  md_mult_mac i_md_mult_mac (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .start_i (mul_start),
    .req_i   (req_i),
    .res_o   (mul_res)
  );

  md_div_serial i_md_div_serial (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .start_i (div_start),
    .req_i   (req_i),
    .res_o   (div_res)
  );

endmodule

// File: rtl/md_sequencer.sv
// Routes an accepted start to the multiplier or the divider, then holds
// the finished result until the requester raises ready_i.

`include "md_settings.svh"

module md_sequencer
  import md_data_pkg::*;
(
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                start_i,
  input  md_req_t             req_i,
  input  md_res_t             mul_res_i,
  input  md_res_t             div_res_i,
  input  logic                ready_i,
  output logic                mul_start_o,
  output logic                div_start_o,
  output logic                busy_o,
  output logic                valid_o,
  output logic [`MD_XLEN-1:0] result_o
);

  logic                run_q;
  logic                valid_q;
  logic [`MD_XLEN-1:0] result_q;
  logic                accept;
  logic                unit_done;

  assign busy_o    = run_q | valid_q;
  assign accept    = start_i & ~busy_o;
  assign unit_done = mul_res_i.done | div_res_i.done;

  // Top funct3 bit picks the unit
  assign div_start_o = accept & req_i.funct[`MD_F3_DIV_BIT];
  assign mul_start_o = accept & ~req_i.funct[`MD_F3_DIV_BIT];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      run_q   <= 1'b0;
      valid_q <= 1'b0;
    end else begin
      if (accept) begin
        run_q <= 1'b1;
      end else if (unit_done) begin
        run_q <= 1'b0;
      end
      if (unit_done) begin
        valid_q <= 1'b1;
      end else if (ready_i) begin
        valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (unit_done) begin
      result_q <= mul_res_i.done ? mul_res_i.value : div_res_i.value;
    end
  end

  assign valid_o  = valid_q;
  assign result_o = result_q;

  // Only one operation is in flight, so the units never finish together
  a_single_done: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(mul_res_i.done && div_res_i.done));

  a_hold_result: assert property (@(posedge clk_i) disable iff (!rst_ni)
    valid_o && !ready_i |=> valid_o && $stable(result_o));

endmodule

// File: rtl/md_div_serial.sv
// Radix-2 restoring divider for DIV, DIVU, REM and REMU.
// Works on absolute values and fixes the sign in a last step.
// A zero divisor finishes one step after start.

`include "md_settings.svh"

module md_div_serial
  import md_data_pkg::*;
(
  input  logic    clk_i,
  input  logic    rst_ni,
  input  logic    start_i,
  input  md_req_t req_i,
  output md_res_t res_o
);

  typedef enum logic [2:0] {
    DIV_IDLE,
    DIV_ABS_A,
    DIV_ABS_B,
    DIV_COMP,
    DIV_LAST,
    DIV_SIGN
  } div_state_e;

  div_state_e             state_q, state_d;
  md_req_t                req_q;
  logic [`MD_XLEN-1:0]    rem_q, rem_d;
  logic [`MD_XLEN-1:0]    quot_q, quot_d;
  logic [`MD_XLEN-1:0]    numer_q, numer_d;
  logic [`MD_XLEN-1:0]    denom_q, denom_d;
  logic [`MD_CNT_W-1:0]   cnt_q, cnt_d;
  logic                   done_q, done_d;

  logic [`MD_XLEN:0]      sub_a, sub_b, diff;
  logic [`MD_XLEN:0]      shifted;
  logic                   ge;
  logic                   sign_a, sign_b, neg_res;
  logic                   div_by_zero;

  assign sign_a      = ~req_q.funct.div.uns & req_q.op_a[`MD_XLEN-1];
  assign sign_b      = ~req_q.funct.div.uns & req_q.op_b[`MD_XLEN-1];
  // Quotient takes the XOR of the signs, remainder follows the dividend
  assign neg_res     = req_q.funct.div.rem ? sign_a : (sign_a ^ sign_b);
  assign div_by_zero = (req_q.op_b == '0);

  // Partial remainder with the next numerator bit shifted in
  assign shifted = {rem_q, numer_q[cnt_q]};

  // Shared subtractor for negation and the trial subtract
  assign diff = sub_a - sub_b;
  // Partial remainder stays below twice the divisor, so bit 32 is the borrow
  assign ge   = ~diff[`MD_XLEN];

  always_comb begin
    state_d = state_q;
    rem_d   = rem_q;
    quot_d  = quot_q;
    numer_d = numer_q;
    denom_d = denom_q;
    cnt_d   = cnt_q;
    done_d  = 1'b0;
    sub_a   = shifted;
    sub_b   = {1'b0, denom_q};

    unique case (state_q)
      DIV_IDLE: begin
        if (start_i) begin
          state_d = DIV_ABS_A;
        end
      end

      DIV_ABS_A: begin
        sub_a = '0;
        sub_b = {1'b0, req_q.op_a};
        if (div_by_zero) begin
          rem_d   = req_q.funct.div.rem ? req_q.op_a : '1;
          done_d  = 1'b1;
          state_d = DIV_IDLE;
        end else begin
          numer_d = sign_a ? diff[`MD_XLEN-1:0] : req_q.op_a;
          state_d = DIV_ABS_B;
        end
      end

      DIV_ABS_B: begin
        sub_a   = '0;
        sub_b   = {1'b0, req_q.op_b};
        denom_d = sign_b ? diff[`MD_XLEN-1:0] : req_q.op_b;
        rem_d   = '0;
        quot_d  = '0;
        cnt_d   = '1;
        state_d = DIV_COMP;
      end

      DIV_COMP: begin
        rem_d  = ge ? diff[`MD_XLEN-1:0] : shifted[`MD_XLEN-1:0];
        quot_d = {quot_q[`MD_XLEN-2:0], ge};
        cnt_d  = cnt_q - 1'b1;
        if (cnt_q == '0) begin
          state_d = DIV_LAST;
        end
      end

      DIV_LAST: begin
        // rem_q now carries whichever value is returned
        if (!req_q.funct.div.rem) begin
          rem_d = quot_q;
        end
        state_d = DIV_SIGN;
      end

      DIV_SIGN: begin
        sub_a = '0;
        sub_b = {1'b0, rem_q};
        if (neg_res) begin
          rem_d = diff[`MD_XLEN-1:0];
        end
        done_d  = 1'b1;
        state_d = DIV_IDLE;
      end

      default: begin
        state_d = DIV_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= DIV_IDLE;
      cnt_q   <= '0;
      done_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
      done_q  <= done_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (start_i) begin
      req_q <= req_i;
    end
    rem_q   <= rem_d;
    quot_q  <= quot_d;
    numer_q <= numer_d;
    denom_q <= denom_d;
  end

  assign res_o.done  = done_q;
  assign res_o.value = rem_q;

  a_state_legal: assert property (@(posedge clk_i) disable iff (!rst_ni)
    state_q inside {DIV_IDLE, DIV_ABS_A, DIV_ABS_B, DIV_COMP, DIV_LAST, DIV_SIGN});

endmodule

// File: rtl/md_mult_mac.sv
// Sequential multiplier built around one signed 17x17 multiply-accumulate.
// MUL finishes in three steps, the MULH kinds in four.

`include "md_settings.svh"

module md_mult_mac
  import md_op_pkg::*;
  import md_data_pkg::*;
(
  input  logic    clk_i,
  input  logic    rst_ni,
  input  logic    start_i,
  input  md_req_t req_i,
  output md_res_t res_o
);

  localparam int unsigned AccW = 2 * `MD_HALF + 2;

  typedef enum logic [1:0] {
    STEP_ALBL,
    STEP_ALBH,
    STEP_AHBL,
    STEP_AHBH
  } step_e;

  step_e              step_q, step_d;
  logic               run_q;
  logic               done_q, done_d;
  md_req_t            req_q;
  logic [AccW-1:0]    acc_q, acc_d;
  logic [AccW-1:0]    accum;
  logic signed [AccW-1:0] mac;

  md_half_t           a_lo, a_hi, b_lo, b_hi;
  md_half_t           mul_a, mul_b;
  logic               sign_a, sign_b;
  md_mul_kind_e       kind;
  logic               a_signed, b_signed, signed_mult;

  assign a_lo = req_q.op_a[`MD_HALF-1:0];
  assign a_hi = req_q.op_a[`MD_XLEN-1:`MD_HALF];
  assign b_lo = req_q.op_b[`MD_HALF-1:0];
  assign b_hi = req_q.op_b[`MD_XLEN-1:`MD_HALF];

  assign kind        = req_q.funct.mul.kind;
  assign a_signed    = (kind == MD_MULH) || (kind == MD_MULHSU);
  assign b_signed    = (kind == MD_MULH);
  assign signed_mult = a_signed | b_signed;

  // The product fits in 34 bits, so the sum is taken at accumulator width
  assign mac = $signed({sign_a, mul_a}) * $signed({sign_b, mul_b}) + $signed(accum);

  always_comb begin
    mul_a  = a_lo;
    mul_b  = b_lo;
    sign_a = 1'b0;
    sign_b = 1'b0;
    accum  = '0;
    acc_d  = mac;
    step_d = step_q;
    done_d = 1'b0;

    unique case (step_q)
      STEP_ALBL: begin
        step_d = STEP_ALBH;
      end

      STEP_ALBH: begin
        mul_b  = b_hi;
        sign_b = b_signed & req_q.op_b[`MD_XLEN-1];
        // Low product is unsigned, only its upper half carries on
        accum  = {{(AccW - `MD_HALF){1'b0}}, acc_q[2*`MD_HALF-1:`MD_HALF]};
        if (kind == MD_MUL) begin
          acc_d = {2'b00, mac[`MD_HALF-1:0], acc_q[`MD_HALF-1:0]};
        end
        step_d = STEP_AHBL;
      end

      STEP_AHBL: begin
        mul_a  = a_hi;
        sign_a = a_signed & req_q.op_a[`MD_XLEN-1];
        if (kind == MD_MUL) begin
          accum  = {{(AccW - `MD_HALF){1'b0}}, acc_q[2*`MD_HALF-1:`MD_HALF]};
          acc_d  = {2'b00, mac[`MD_HALF-1:0], acc_q[`MD_HALF-1:0]};
          step_d = STEP_ALBL;
          done_d = 1'b1;
        end else begin
          accum  = acc_q;
          step_d = STEP_AHBH;
        end
      end

      STEP_AHBH: begin
        mul_a  = a_hi;
        mul_b  = b_hi;
        sign_a = a_signed & req_q.op_a[`MD_XLEN-1];
        sign_b = b_signed & req_q.op_b[`MD_XLEN-1];
        // Shift the middle sum down, keeping its sign for signed kinds
        accum  = {{`MD_HALF{signed_mult & acc_q[AccW-1]}}, acc_q[AccW-1:`MD_HALF]};
        step_d = STEP_ALBL;
        done_d = 1'b1;
      end

      default: begin
        step_d = STEP_ALBL;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      run_q  <= 1'b0;
      step_q <= STEP_ALBL;
      done_q <= 1'b0;
    end else begin
      done_q <= run_q & done_d;
      if (start_i) begin
        run_q <= 1'b1;
      end else if (run_q && done_d) begin
        run_q <= 1'b0;
      end
      if (run_q) begin
        step_q <= step_d;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (start_i) begin
      req_q <= req_i;
    end
    if (run_q) begin
      acc_q <= acc_d;
    end
  end

  assign res_o.done  = done_q;
  assign res_o.value = acc_q[`MD_XLEN-1:0];

  a_step_known: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !$isunknown(step_q));

  // The sequencer must not restart the unit mid-multiply
  a_no_start_busy: assert property (@(posedge clk_i) disable iff (!rst_ni)
    start_i |-> !run_q);

endmodule

// File: rtl/md_data_pkg.sv
// Data types passed between the sequencer and the two arithmetic units.
// A request carries funct3 and both operands; a unit answers with a result.

`include "md_settings.svh"

package md_data_pkg;

  import md_op_pkg::*;

  // One operand half as seen by the multiplier
  typedef logic [`MD_HALF-1:0] md_half_t;

  // Request issued with a start pulse
  typedef struct packed {
    md_funct_u             funct;
    logic [`MD_XLEN-1:0]   op_a;
    logic [`MD_XLEN-1:0]   op_b;
  } md_req_t;

  // Unit result whose done bit is high for exactly one cycle
  typedef struct packed {
    logic                  done;
    logic [`MD_XLEN-1:0]   value;
  } md_res_t;

endpackage

// File: rtl/md_op_pkg.sv
// Operation encoding for the RV32M unit.
// The funct3 word is read through one of two views, picked by its top bit.

package md_op_pkg;

  // Multiply kinds as coded in the low two funct3 bits
  typedef enum logic [1:0] {
    MD_MUL    = 2'b00,
    MD_MULH   = 2'b01,
    MD_MULHSU = 2'b10,
    MD_MULHU  = 2'b11
  } md_mul_kind_e;

  // Multiply view of funct3 with a zero top bit
  typedef struct packed {
    logic         is_div;
    md_mul_kind_e kind;
  } md_mul_view_t;

  // Divide view of funct3 with a one top bit
  typedef struct packed {
    logic is_div;
    logic rem;
    logic uns;
  } md_div_view_t;

  // One funct3 word decoded as multiply or as divide
  typedef union packed {
    md_mul_view_t mul;
    md_div_view_t div;
  } md_funct_u;

endpackage

// File: rtl/md_settings.svh
// Sizes and funct3 field positions for the RV32M multiply/divide unit.
// Include ahead of any package or module that uses the MD_* macros.

`ifndef MD_SETTINGS_SVH
`define MD_SETTINGS_SVH

// Operand and result width
`define MD_XLEN 32

// Width of one half word fed to the 17-bit multiplier
`define MD_HALF 16

// Divider step counter wide enough for MD_XLEN compare steps
`define MD_CNT_W 5

// funct3 bit that selects divide (1) over multiply (0)
`define MD_F3_DIV_BIT 2

`endif
